// File: predecode.f
+incdir+include
hw/predecodePkg.sv
hw/instrClassifier.sv
hw/boundaryStage.sv
hw/slotCompactor.sv
hw/predecodeTop.sv
tests/predecodeTb.sv

// File: Bender.yml
package:
  name: predecode

sources:
  - files:
      - hw/predecodePkg.sv
      - hw/instrClassifier.sv
      - hw/boundaryStage.sv
      - hw/slotCompactor.sv
      - hw/predecodeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/predecodeTb.sv

// File: include/predecodeTbModel.svh
`ifndef PREDECODE_TB_MODEL_SVH
`define PREDECODE_TB_MODEL_SVH

localparam int tbSlotCount     = 12;
localparam int tbJumpSlotCount = 4;

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

// class bits straight from the opcode table
function automatic predecodePkg::instrClassT modelClass(input logic [7:0] op,
                                                        input logic longForm);
  predecodePkg::instrClassT c;
  c = '0;
  if (longForm) begin
    if (op <= 8'd31) begin
      c.mul = op[2];
      c.alu = ~op[2];
    end else if (op inside {[8'd40:8'd45]}) begin
      c.shift = 1'b1;
    end else if (op inside {[8'd46:8'd51]}) begin
      c.alu = 1'b1;
    end else if (op inside {[8'd64:8'd127]}) begin
      c.store = op[0];
      c.load  = ~op[0];
    end else if (op inside {[8'd160:8'd180]}) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else if (op == 8'd181) begin
      c.jump = 1'b1;
    end else if (op == 8'd182) begin
      c.jump  = 1'b1;
      c.indir = 1'b1;
    end else if (op inside {[8'd240:8'd243]}) begin
      c.fpu = 1'b1;
    end else if (op == 8'd255) begin
      c.sys = 1'b1;
    end
  end else begin
    if (op[5:0] <= 6'd31) begin
      c.alu = 1'b1;
    end else if (op[5:0] <= 6'd47) begin
      c.shift = 1'b1;
    end else if (op[5:0] <= 6'd51) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else begin
      c.fpu = 1'b1;
    end
  end
  return c;
endfunction

// expected outputs for one bundle
function automatic void predecodeModel(
  input  predecodePkg::bundleT                          bundle,
  input  logic [3:0]                                    startOff,
  output predecodePkg::instrSlotT [tbSlotCount-1:0]     slots,
  output logic [tbSlotCount-1:0]                        instrEn,
  output predecodePkg::instrSlotT [tbJumpSlotCount-1:0] jumps,
  output logic [tbJumpSlotCount-1:0]                    jumpEn,
  output logic                                          hasJumps,
  output logic                                          error
);
  logic [14:0]             ends;
  logic [303:0]            ext;
  logic [17:0]             endExt;
  predecodePkg::instrSlotT s;
  int                      nInstr;
  int                      nJump;
  ends     = bundle[254:240];
  ext      = {64'b0, bundle[239:0]};
  endExt   = {3'b000, ends};
  slots    = '0;
  instrEn  = '0;
  jumps    = '0;
  jumpEn   = '0;
  nInstr   = 0;
  nJump    = 0;
  for (int k = 0; k < 15; k++) begin
    if ((k == 0 || ends[k-1]) && k >= startOff) begin
      s.off   = k[3:0];
      s.instr = ext[k*16 +: 80];
      s.magic = ~endExt[k +: 4];
      s.cls   = modelClass(s.instr[7:0], s.magic[0]);
      if (nInstr < tbSlotCount) begin
        slots[nInstr]   = s;
        instrEn[nInstr] = 1'b1;
      end
      if (s.cls.jump) begin
        if (nJump < tbJumpSlotCount) begin
          jumps[nJump]  = s;
          jumpEn[nJump] = 1'b1;
        end
        nJump++;
      end
      nInstr++;
    end
  end
  hasJumps = (nJump != 0);
  error    = (nInstr > tbSlotCount) || (startOff == 4'hf);
endfunction

`endif

// File: tests/predecodeTb.sv
`timescale 1ns/1ps
`default_nettype none

module predecodeTb;
  import predecodePkg::*;
  `include "predecodeTbModel.svh"

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 16;
  localparam int maxRows     = 64;

  logic clk;
  logic reset;
  bundleT bundle;
  logic [offBits-1:0] startOff;
  instrSlotT [tbSlotCount-1:0] slots;
  logic [tbSlotCount-1:0] instrEn;
  instrSlotT [tbJumpSlotCount-1:0] jumps;
  logic [tbJumpSlotCount-1:0] jumpEn;
  logic hasJumps;
  logic error;

  // stimulus table and model results
  string rowName [maxRows];
  bundleT bundleTab [maxRows];
  logic [offBits-1:0] offTab [maxRows];
  instrSlotT [tbSlotCount-1:0] expSlots [maxRows];
  logic [tbSlotCount-1:0] expInstrEn [maxRows];
  instrSlotT [tbJumpSlotCount-1:0] expJumps [maxRows];
  logic [tbJumpSlotCount-1:0] expJumpEn [maxRows];
  logic expHasJumps [maxRows];
  logic expError [maxRows];

  int nRows = 0;
  int passCnt = 0;
  int failCnt = 0;
  logic tableReady = 1'b0;
  logic [15:0] lfsr = 16'd88;
  bundleT rb;

  predecodeTop #(
    .slotCount    (tbSlotCount),
    .jumpSlotCount(tbJumpSlotCount)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .bundle  (bundle),
    .startOff(startOff),
    .slots   (slots),
    .instrEn (instrEn),
    .jumps   (jumps),
    .jumpEn  (jumpEn),
    .hasJumps(hasJumps),
    .error   (error)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // parcel k holds base+k, a short conditional jump where jumpAt is set
  function automatic bundleT makeBundle(input logic [14:0] ends, input logic [15:0] base,
                                        input logic [14:0] jumpAt);
    bundleT b;
    b = '0;
    for (int k = 0; k < parcelCount; k++) begin
      b[k*parcelBits +: parcelBits] = jumpAt[k] ? 16'h0031 : base + 16'(k);
    end
    b[254:240] = ends;
    return b;
  endfunction

  function automatic bundleT classBundle(input logic [7:0] op, input logic longForm);
    bundleT b;
    b = '0;
    b[15:0] = {8'ha5, op};  // upper byte must not matter
    b[254:240] = longForm ? 15'h0002 : 15'h0001;
    return b;
  endfunction

  task automatic addRow(input string name, input bundleT b, input logic [3:0] off);
    instrSlotT [tbSlotCount-1:0] s;
    logic [tbSlotCount-1:0] en;
    instrSlotT [tbJumpSlotCount-1:0] j;
    logic [tbJumpSlotCount-1:0] je;
    logic hj;
    logic er;
    predecodeModel(b, off, s, en, j, je, hj, er);
    rowName[nRows] = name;
    bundleTab[nRows] = b;
    offTab[nRows] = off;
    expSlots[nRows] = s;
    expInstrEn[nRows] = en;
    expJumps[nRows] = j;
    expJumpEn[nRows] = je;
    expHasJumps[nRows] = hj;
    expError[nRows] = er;
    nRows++;
  endtask

  // one lfsr step per bit taken
  task automatic randomBundle(output bundleT b);
    b = '0;
    for (int i = 0; i < 255; i++) begin
      lfsr = lfsrStep(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic randomOff(output logic [3:0] off);
    for (int i = 0; i < 4; i++) begin
      lfsr = lfsrStep(lfsr);
      off[i] = lfsr[0];
    end
  endtask

  // everything cleared once reset has gone through both stages
  task automatic checkReset();
    int bad;
    bad = 0;
    if (slots !== '0) begin
      $display("FAILED %0t slots expected 0 got %h", $time, slots);
      bad++;
    end
    if (instrEn !== '0) begin
      $display("FAILED %0t instrEn expected 0 got %b", $time, instrEn);
      bad++;
    end
    if (jumps !== '0) begin
      $display("FAILED %0t jumps expected 0 got %h", $time, jumps);
      bad++;
    end
    if (jumpEn !== '0) begin
      $display("FAILED %0t jumpEn expected 0 got %b", $time, jumpEn);
      bad++;
    end
    if (hasJumps !== 1'b0) begin
      $display("FAILED %0t hasJumps expected 0 got %b", $time, hasJumps);
      bad++;
    end
    if (error !== 1'b0) begin
      $display("FAILED %0t error expected 0 got %b", $time, error);
      bad++;
    end
    if (bad == 0) begin
      passCnt++;
      $display("reset state ok");
    end else begin
      failCnt++;
      $display("reset state has %0d wrong outputs", bad);
    end
  endtask

  task automatic checkRow(input int r);
    int bad;
    bad = 0;
    if (slots !== expSlots[r]) begin
      $display("FAILED %0t slots expected %h got %h", $time, expSlots[r], slots);
      bad++;
    end
    if (instrEn !== expInstrEn[r]) begin
      $display("FAILED %0t instrEn expected %b got %b", $time, expInstrEn[r], instrEn);
      bad++;
    end
    if (jumps !== expJumps[r]) begin
      $display("FAILED %0t jumps expected %h got %h", $time, expJumps[r], jumps);
      bad++;
    end
    if (jumpEn !== expJumpEn[r]) begin
      $display("FAILED %0t jumpEn expected %b got %b", $time, expJumpEn[r], jumpEn);
      bad++;
    end
    if (hasJumps !== expHasJumps[r]) begin
      $display("FAILED %0t hasJumps expected %b got %b", $time, expHasJumps[r], hasJumps);
      bad++;
    end
    if (error !== expError[r]) begin
      $display("FAILED %0t error expected %b got %b", $time, expError[r], error);
      bad++;
    end
    if (bad == 0) begin
      passCnt++;
      $display("row %0d %s ok", r, rowName[r]);
    end else begin
      failCnt++;
      $display("row %0d %s has %0d wrong outputs", r, rowName[r], bad);
    end
  endtask

  initial begin
    logic [3:0] ro;
    clk = 1'b0;
    reset = 1'b1;
    bundle = '0;
    startOff = '0;

    addRow("full packing", makeBundle(15'h7fff, 16'h0000, 15'h0), 4'd0);
    addRow("mixed lengths off 3", makeBundle(15'h4a26, 16'h1140, 15'h0), 4'd3);
    addRow("mixed lengths off 5", makeBundle(15'h3149, 16'h20a0, 15'h0), 4'd5);
    addRow("mixed lengths off 14", makeBundle(15'h5555, 16'h00f0, 15'h0), 4'd14);
    addRow("long alu", classBundle(8'd3, 1'b1), 4'd0);
    addRow("long mul", classBundle(8'd4, 1'b1), 4'd0);
    addRow("long shift", classBundle(8'd42, 1'b1), 4'd0);
    addRow("long cmp", classBundle(8'd48, 1'b1), 4'd0);
    addRow("long load", classBundle(8'd64, 1'b1), 4'd0);
    addRow("long store", classBundle(8'd65, 1'b1), 4'd0);
    addRow("long cond jump", classBundle(8'd170, 1'b1), 4'd0);
    addRow("long jump", classBundle(8'd181, 1'b1), 4'd0);
    addRow("long indirect jump", classBundle(8'd182, 1'b1), 4'd0);
    addRow("long fpu", classBundle(8'd241, 1'b1), 4'd0);
    addRow("long sys", classBundle(8'd255, 1'b1), 4'd0);
    addRow("long none", classBundle(8'd200, 1'b1), 4'd0);
    addRow("short alu", classBundle(8'hc5, 1'b0), 4'd0);
    addRow("short shift", classBundle(8'd40, 1'b0), 4'd0);
    addRow("short cond jump", classBundle(8'd50, 1'b0), 4'd0);
    addRow("short fpu", classBundle(8'd60, 1'b0), 4'd0);
    addRow("no jumps", makeBundle(15'h7fff, 16'h0000, 15'h0), 4'd3);
    addRow("two jumps", makeBundle(15'h7fff, 16'h0000, 15'h0208), 4'd3);
    addRow("six jumps", makeBundle(15'h7fff, 16'h0000, 15'h2496), 4'd0);
    for (int i = 0; i < 40; i++) begin
      randomBundle(rb);
      randomOff(ro);
      addRow($sformatf("random %0d", i), rb, ro);
      if (i == 20) begin
        addRow("bad offset", rb, 4'd15);
      end
    end
    tableReady = 1'b1;

    repeat (resetCycles) @(posedge clk);
    #2;
    reset = 1'b0;
    checkReset();
    bundle = bundleTab[0];
    startOff = offTab[0];

    // two stages, so row c-2 is on the outputs now
    for (int c = 1; c < nRows + 2; c++) begin
      @(posedge clk);
      #2;
      if (c >= 2) begin
        checkRow(c - 2);
      end
      if (c < nRows) begin
        bundle = bundleTab[c];
        startOff = offTab[c];
      end
    end

    $display("%0d tests passed, %0d failed", passCnt, failCnt);
    if (failCnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (tableReady);
    #((nRows + resetCycles + 10) * clkPeriod);
    $display("timeout, the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/predecodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module predecodeTop #(
  parameter int slotCount     = 12,
  parameter int jumpSlotCount = 4
) (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire predecodePkg::bundleT                   bundle,
  input  wire [predecodePkg::offBits-1:0]             startOff,
  output predecodePkg::instrSlotT [slotCount-1:0]     slots,
  output logic [slotCount-1:0]                        instrEn,
  output predecodePkg::instrSlotT [jumpSlotCount-1:0] jumps,
  output logic [jumpSlotCount-1:0]                    jumpEn,
  output logic                                        hasJumps,
  output logic                                        error
);
  import predecodePkg::*;

  candidateT [parcelCount-1:0] candidates;  // stage 1 to stage 2
  logic                        startOffBad;

  boundaryStage boundary_i (
    .clk        (clk),
    .reset      (reset),
    .bundle     (bundle),
    .startOff   (startOff),
    .candidates (candidates),
    .startOffBad(startOffBad)
  );

  slotCompactor #(
    .slotCount    (slotCount),
    .jumpSlotCount(jumpSlotCount)
  ) compactor_i (
    .clk        (clk),
    .reset      (reset),
    .candidates (candidates),
    .startOffBad(startOffBad),
    .slots      (slots),
    .instrEn    (instrEn),
    .jumps      (jumps),
    .jumpEn     (jumpEn),
    .hasJumps   (hasJumps),
    .error      (error)
  );

endmodule

`default_nettype wire

// File: hw/slotCompactor.sv
`timescale 1ns/1ps
`default_nettype none

module slotCompactor #(
  parameter int slotCount     = 12,
  parameter int jumpSlotCount = 4
) (
  input  wire                                                   clk,
  input  wire                                                   reset,
  input  wire predecodePkg::candidateT [predecodePkg::parcelCount-1:0] candidates,
  input  wire                                                   startOffBad,
  output predecodePkg::instrSlotT [slotCount-1:0]               slots,
  output logic [slotCount-1:0]                                  instrEn,
  output predecodePkg::instrSlotT [jumpSlotCount-1:0]           jumps,
  output logic [jumpSlotCount-1:0]                              jumpEn,
  output logic                                                  hasJumps,
  output logic                                                  error
);
  import predecodePkg::*;

  localparam int cntBits = $clog2(parcelCount + 1);

  logic [cntBits-1:0]             instrCnt [parcelCount+1];  // valid candidates below k
  logic [cntBits-1:0]             jumpCnt [parcelCount+1];   // valid jumps below k
  logic [parcelCount-1:0]         isJump;
  instrSlotT [slotCount-1:0]      slotsNext;
  logic [slotCount-1:0]           instrEnNext;
  instrSlotT [jumpSlotCount-1:0]  jumpsNext;
  logic [jumpSlotCount-1:0]       jumpEnNext;
  logic                           hasJumpsNext;
  logic                           errorNext;

  // prefix counts
  always_comb begin
    instrCnt[0] = '0;
    jumpCnt[0]  = '0;
    for (int k = 0; k < parcelCount; k++) begin
      isJump[k]     = candidates[k].valid && candidates[k].slot.cls.jump;
      instrCnt[k+1] = instrCnt[k] + cntBits'(candidates[k].valid);
      jumpCnt[k+1]  = jumpCnt[k] + cntBits'(isJump[k]);
    end
  end

  // slot i takes the one valid candidate with i valid ones ahead of it
  always_comb begin
    slotsNext   = '0;
    instrEnNext = '0;
    for (int i = 0; i < slotCount; i++) begin
      for (int k = 0; k < parcelCount; k++) begin
        if (candidates[k].valid && int'(instrCnt[k]) == i) begin
          slotsNext[i]   = candidates[k].slot;
          instrEnNext[i] = 1'b1;
        end
      end
    end
  end

  // same packing over jumps only, later jumps beyond the list are dropped
  always_comb begin
    jumpsNext  = '0;
    jumpEnNext = '0;
    for (int j = 0; j < jumpSlotCount; j++) begin
      for (int k = 0; k < parcelCount; k++) begin
        if (isJump[k] && int'(jumpCnt[k]) == j) begin
          jumpsNext[j]  = candidates[k].slot;
          jumpEnNext[j] = 1'b1;
        end
      end
    end
  end

  assign hasJumpsNext = (jumpCnt[parcelCount] != '0);

  // more instructions than slots, or nothing left after the offset
  assign errorNext = (int'(instrCnt[parcelCount]) > slotCount) || startOffBad;

  always_ff @(posedge clk) begin
    slots <= slotsNext;
    jumps <= jumpsNext;
    if (reset) begin
      instrEn  <= '0;
      jumpEn   <= '0;
      hasJumps <= 1'b0;
      error    <= 1'b0;
    end else begin
      instrEn  <= instrEnNext;
      jumpEn   <= jumpEnNext;
      hasJumps <= hasJumpsNext;
      error    <= errorNext;
    end
  end

endmodule

`default_nettype wire

// File: hw/boundaryStage.sv
`timescale 1ns/1ps
`default_nettype none

module boundaryStage (
  input  wire                                                   clk,
  input  wire                                                   reset,
  input  wire predecodePkg::bundleT                             bundle,
  input  wire [predecodePkg::offBits-1:0]                       startOff,
  output predecodePkg::candidateT [predecodePkg::parcelCount-1:0] candidates,
  output logic                                                  startOffBad
);
  import predecodePkg::*;

  localparam int padBits = (maxParcels - 1) * parcelBits;

  logic [parcelCount-1:0]            endMark;
  logic [parcelCount-1:0]            isStart;
  logic [endMarkLsb+padBits-1:0]     parcelsExt;
  logic [parcelCount+magicBits-2:0]  endExt;
  logic [magicBits-1:0]              magicK [parcelCount];
  instrClassT                        clsK [parcelCount];
  candidateT [parcelCount-1:0]       candNext;

  assign endMark = bundle[endMarkLsb +: parcelCount];

  // parcel 0 always starts, parcel k starts after an end at k-1
  assign isStart = {endMark[parcelCount-2:0], 1'b1};

  // windows near the top run into zero parcels
  assign parcelsExt = {{padBits{1'b0}}, bundle[endMarkLsb-1:0]};

  // missing end marks read as no end, so magic sees ones there
  assign endExt = {{(magicBits-1){1'b0}}, endMark};

  for (genvar k = 0; k < parcelCount; k++) begin : genParcel
    assign magicK[k] = ~endExt[k +: magicBits];

    instrClassifier classifier_i (
      .window(parcelsExt[k*parcelBits +: instrBits]),
      .magic (magicK[k]),
      .cls   (clsK[k])
    );
  end

  always_comb begin
    for (int k = 0; k < parcelCount; k++) begin
      candNext[k].valid      = isStart[k] && (offBits'(k) >= startOff);  // below startOff dropped
      candNext[k].slot.cls   = clsK[k];
      candNext[k].slot.magic = magicK[k];
      candNext[k].slot.instr = parcelsExt[k*parcelBits +: instrBits];
      candNext[k].slot.off   = offBits'(k);
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < parcelCount; k++) begin
      candidates[k].slot <= candNext[k].slot;
    end
    if (reset) begin
      for (int k = 0; k < parcelCount; k++) begin
        candidates[k].valid <= 1'b0;
      end
      startOffBad <= 1'b0;
    end else begin
      for (int k = 0; k < parcelCount; k++) begin
        candidates[k].valid <= candNext[k].valid;
      end
      // offset 15 is past the last parcel, flagged downstream
      startOffBad <= (startOff == {offBits{1'b1}});
    end
  end

endmodule

`default_nettype wire

// File: hw/instrClassifier.sv
`timescale 1ns/1ps
`default_nettype none

module instrClassifier (
  input  wire [predecodePkg::instrBits-1:0] window,
  input  wire [predecodePkg::magicBits-1:0] magic,
  output predecodePkg::instrClassT          cls
);
  import predecodePkg::*;

  logic [7:0] opMain;
  logic [5:0] opSub;
  opGroupT    grp;

  assign opMain = window[7:0];
  assign opSub  = window[5:0];

  // magic bit 0 set means the first parcel does not end the instruction
  always_comb begin
    grp = grpNone;
    if (magic[0]) begin
      if (opMain <= 8'd31) begin
        grp = opMain[2] ? grpMul : grpAlu;
      end else if (opMain inside {[8'd40:8'd45]}) begin
        grp = grpShift;
      end else if (opMain inside {[8'd46:8'd51]}) begin
        grp = grpCmp;
      end else if (opMain inside {[8'd64:8'd127]}) begin
        grp = opMain[0] ? grpStore : grpLoad;  // odd opcodes store
      end else if (opMain inside {[8'd160:8'd180]}) begin
        grp = grpCondJump;
      end else if (opMain == 8'd181) begin
        grp = grpJump;
      end else if (opMain == 8'd182) begin
        grp = grpIndirJump;
      end else if (opMain inside {[8'd240:8'd243]}) begin
        grp = grpFpu;
      end else if (opMain == 8'd255) begin
        grp = grpSys;
      end
    end else begin
      // short form covers the whole 6-bit space
      if (opSub <= 6'd31) begin
        grp = grpAlu;
      end else if (opSub <= 6'd47) begin
        grp = grpShift;
      end else if (opSub <= 6'd51) begin
        grp = grpCondJump;
      end else begin
        grp = grpFpu;
      end
    end
  end

  always_comb begin
    cls = '0;
    case (grp)
      grpAlu, grpCmp: cls.alu = 1'b1;
      grpMul:         cls.mul = 1'b1;
      grpShift:       cls.shift = 1'b1;
      grpLoad:        cls.load = 1'b1;
      grpStore:       cls.store = 1'b1;
      grpCondJump: begin
        cls.jump = 1'b1;
        cls.alu  = 1'b1;  // condition evaluated in an alu
      end
      grpJump:        cls.jump = 1'b1;
      grpIndirJump: begin
        cls.jump  = 1'b1;
        cls.indir = 1'b1;
      end
      grpFpu:         cls.fpu = 1'b1;
      grpSys:         cls.sys = 1'b1;
      default:        cls = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/predecodePkg.sv
`default_nettype none

package predecodePkg;

  // bundle geometry
  localparam int parcelCount = 15;
  localparam int parcelBits  = 16;
  localparam int maxParcels  = 5;  // longest instruction, in parcels
  localparam int instrBits   = maxParcels * parcelBits;
  localparam int magicBits   = 4;
  localparam int offBits     = 4;

  localparam int bundleBits  = 256;
  localparam int endMarkLsb  = parcelCount * parcelBits;  // end marks sit above the parcels

  typedef logic [bundleBits-1:0] bundleT;  // bit 255 unused

  // opcode groups, both encodings decode into these
  typedef enum logic [3:0] {
    grpNone,
    grpAlu,
    grpMul,
    grpShift,
    grpCmp,
    grpLoad,
    grpStore,
    grpCondJump,
    grpJump,
    grpIndirJump,
    grpFpu,
    grpSys
  } opGroupT;

  typedef struct packed {
    logic jump;
    logic indir;   // target from a register
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } instrClassT;

  // one decoded instruction as it leaves the predecoder
  typedef struct packed {
    instrClassT           cls;
    logic [magicBits-1:0] magic;
    logic [instrBits-1:0] instr;
    logic [offBits-1:0]   off;    // parcel of the first instruction word
  } instrSlotT;

  typedef struct packed {
    logic      valid;
    instrSlotT slot;
  } candidateT;

endpackage

`default_nettype wire
